/* project.f */
+incdir+tests
src/ocl_regs_pkg.sv
src/tick_counter_pkg.sv
src/axil_slave.sv
src/hello_vled_regs.sv
src/tick_counter.sv
src/cl_hello_world.sv
tests/tb_cl_hello_world.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module tb_cl_hello_world -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log \
  || echo "Simulation build or run failed"

grep -qx '\*\* PASS \*\*' sim.log && echo "Result: passed" || { echo "Result: failed"; exit 1; }

/* tests/tb_host_tasks.svh */
// Host bus write/read tasks, handshake waits, LCG random source and expected-value helpers
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Cycles a single handshake may take before it counts as hung
localparam int hs_limit = 16;

typedef enum int {hs_aw, hs_w, hs_b, hs_ar, hs_r} hs_t;

logic [31:0] lcg_state;

// Slave outputs as seen in the cycle of the last transfer
axil_rsp_t rsp_at_hs;

// --------------------------------------------------
// Random source
// --------------------------------------------------
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Upper halves only, low LCG bits repeat quickly
function automatic logic [31:0] rand_word();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = lcg_next();
  lo = lcg_next();
  return {hi[31:16], lo[31:16]};
endfunction

function automatic int unsigned rand_below(int unsigned n);
  logic [31:0] r;
  r = lcg_next();
  return {16'h0, r[31:16]} % n;
endfunction

// --------------------------------------------------
// Model helpers
// --------------------------------------------------
// Hello word comes back with its bytes in reverse order
function automatic logic [31:0] byte_reverse(logic [31:0] w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic logic [31:0] ctrl_word(logic clear, logic load, logic enable);
  cnt_ctrl_t c;
  c.clear  = clear;
  c.load   = load;
  c.enable = enable;
  return {29'h0, c};
endfunction

// --------------------------------------------------
// Bus handshakes
// --------------------------------------------------
function automatic logic rsp_flag(hs_t sel);
  case (sel)
    hs_aw:   return ocl_rsp.awready;
    hs_w:    return ocl_rsp.wready;
    hs_b:    return ocl_rsp.bvalid;
    hs_ar:   return ocl_rsp.arready;
    default: return ocl_rsp.rvalid;
  endcase
endfunction

// Sampled at the falling edge, returns 1 ns after the transfer edge
task automatic await_handshake(input hs_t sel, input string what);
  int cycles;
  cycles = 0;
  @(negedge clk_main_a0);
  while (!rsp_flag(sel) && cycles < hs_limit) begin
    @(negedge clk_main_a0);
    cycles++;
  end
  assert (rsp_flag(sel)) else begin
    $display("%s handshake never completed, gave up at %0t ns", what, $time);
    err_cnt++;
  end
  rsp_at_hs = ocl_rsp;
  @(posedge clk_main_a0);
  #1;
endtask

task automatic idle_cycles(input int n);
  repeat (n) begin
    @(posedge clk_main_a0);
    #1;
  end
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
  ocl_req.awvalid = 1'b1;
  ocl_req.awaddr  = addr;
  ocl_req.wvalid  = 1'b1;
  ocl_req.wdata   = data;
  await_handshake(hs_aw, "Write address");
  ocl_req.awvalid = 1'b0;
  await_handshake(hs_w, "Write data");
  ocl_req.wvalid = 1'b0;
  // Response channel held off for a random stretch
  idle_cycles(rand_below(4));
  ocl_req.bready = 1'b1;
  await_handshake(hs_b, "Write response");
  ocl_req.bready = 1'b0;
  // Write response is always OKAY
  check_cnt++;
  assert (rsp_at_hs.bresp === 2'b00) else begin
    $display("Mismatch at %0t ns: bresp is %b, expected 00", $time, rsp_at_hs.bresp);
    err_cnt++;
  end
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
  ocl_req.arvalid = 1'b1;
  ocl_req.araddr  = addr;
  await_handshake(hs_ar, "Read address");
  ocl_req.arvalid = 1'b0;
  idle_cycles(rand_below(4));
  ocl_req.rready = 1'b1;
  await_handshake(hs_r, "Read data");
  ocl_req.rready = 1'b0;
  // Data as it stood in the transfer cycle
  data = rsp_at_hs.rdata;
  check_cnt++;
  assert (rsp_at_hs.rresp === 2'b00) else begin
    $display("Mismatch at %0t ns: rresp is %b, expected 00", $time, rsp_at_hs.rresp);
    err_cnt++;
  end
endtask

`endif

/* tests/tb_cl_hello_world.sv */
// Testbench for cl_hello_world: clock, reset, watchdog, random register tests and reporting
module tb_cl_hello_world
  import ocl_regs_pkg::*;
  import tick_counter_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period_ns = 8;
  localparam int num_tests     = 6;
  localparam int txn_per_test  = 40;
  // Worst case per bus transaction, every handshake at its limit
  localparam int txn_cycles    = 4 * 16 + 8;
  localparam int watchdog_ns   = num_tests * txn_per_test * txn_cycles * clk_period_ns;

  logic              clk_main_a0 = 1'b0;
  logic              rst_main_n_sync;
  axil_req_t         ocl_req;
  axil_rsp_t         ocl_rsp;
  logic [vled_w-1:0] status_vdip;
  logic [vled_w-1:0] status_vled;

  int check_cnt;
  int err_cnt;
  int test_cnt;
  int test_fail_cnt;

  // Model state
  logic [31:0]       exp_hello;
  logic [cnt_w-1:0]  exp_count;
  logic [cnt_w-1:0]  exp_wmark;
  logic [tick_w-1:0] exp_tick;

  `include "tb_host_tasks.svh"

  always #(clk_period_ns / 2) clk_main_a0 = ~clk_main_a0;

  cl_hello_world UUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before) begin
      test_fail_cnt++;
    end
    $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] wr;
    logic [31:0] prev;
    int          mark;
    lcg_state       = 32'd64;
    ocl_req         = '0;
    status_vdip     = '0;
    rst_main_n_sync = 1'b0;
    check_cnt       = 0;
    err_cnt         = 0;
    test_cnt        = 0;
    test_fail_cnt   = 0;
    repeat (5) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;

    mark = err_cnt;
    compare_word({16'h0, status_vled}, 32'h0, "status_vled after reset");
    bus_read(hello_world_addr, rd);
    compare_word(rd, 32'h0, "hello word after reset");
    report_test("reset state", mark);

    mark = err_cnt;
    for (int i = 0; i < 8; i++) begin
      exp_hello = rand_word();
      bus_write(hello_world_addr, exp_hello);
      bus_read(hello_world_addr, rd);
      compare_word(rd, byte_reverse(exp_hello), "hello readback");
      bus_read(vled_addr, rd);
      compare_word(rd, {16'h0, exp_hello[15:0]}, "vled readback");
    end
    report_test("hello readback", mark);

    // DIP value settles through two sync flops, LED output one more
    mark = err_cnt;
    for (int i = 0; i < 4; i++) begin
      wr          = rand_word();
      status_vdip = wr[15:0];
      exp_hello   = rand_word();
      bus_write(hello_world_addr, exp_hello);
      idle_cycles(6);
      compare_word({16'h0, status_vled}, {16'h0, exp_hello[15:0] & status_vdip}, "status_vled");
    end
    report_test("led masking", mark);

    mark = err_cnt;
    for (int i = 0; i < 6; i++) begin
      wr = rand_word() | 32'h0001_0000;
      bus_read(wr, rd);
      compare_word(rd, 32'hDEAD_DEAD, "unmapped read");
    end
    report_test("unmapped addresses", mark);

    mark = err_cnt;
    for (int i = 0; i < 4; i++) begin
      wr        = rand_word();
      exp_count = wr[15:0];
      exp_wmark = wr[31:16];
      wr        = rand_word();
      exp_tick  = wr[7:0];
      bus_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b0, 1'b0));
      bus_write(cnt_tick_addr, {24'h0, exp_tick});
      bus_write(cnt_wmark_addr, {16'h0, exp_wmark});
      bus_write(cnt_load_addr, {16'h0, exp_count});
      bus_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b1, 1'b0));
      bus_read(cnt_status_addr, rd);
      compare_word(rd, {15'h0, exp_count >= exp_wmark, exp_count}, "status after load");
      bus_read(cnt_tick_addr, rd);
      compare_word(rd, {24'h0, exp_tick}, "tick readback");
      bus_read(cnt_load_addr, rd);
      compare_word(rd, {16'h0, exp_count}, "load readback");
      bus_read(cnt_wmark_addr, rd);
      compare_word(rd, {16'h0, exp_wmark}, "watermark readback");
    end
    report_test("load and watermark", mark);

    // Small tick and low start count, no wrap while running
    mark     = err_cnt;
    wr       = rand_word();
    exp_tick = 8'(rand_below(3));
    bus_write(cnt_tick_addr, {24'h0, exp_tick});
    bus_write(cnt_load_addr, {20'h0, wr[11:0]});
    bus_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b1, 1'b0));
    bus_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b0, 1'b1));
    bus_read(cnt_ctrl_addr, rd);
    compare_word(rd, 32'h1, "control readback");
    bus_read(cnt_status_addr, prev);
    bus_read(cnt_status_addr, rd);
    check_cnt++;
    assert (rd[15:0] != prev[15:0]) else begin
      $display("Mismatch at %0t ns: count stuck at %h while enabled", $time, rd[15:0]);
      err_cnt++;
    end
    bus_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b0, 1'b0));
    bus_read(cnt_status_addr, prev);
    bus_read(cnt_status_addr, rd);
    compare_word({16'h0, rd[15:0]}, {16'h0, prev[15:0]}, "count while disabled");
    bus_write(cnt_ctrl_addr, ctrl_word(1'b1, 1'b0, 1'b0));
    bus_read(cnt_status_addr, rd);
    compare_word({16'h0, rd[15:0]}, 32'h0, "count after clear");
    report_test("enable and clear", mark);

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* src/cl_hello_world.sv */
// Top level: AXI-Lite slave, hello/VLED registers, tick counter and read data merge
module cl_hello_world
  import ocl_regs_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  axil_req_t         ocl_req,
  output axil_rsp_t         ocl_rsp,
  input  logic [vled_w-1:0] status_vdip,
  output logic [vled_w-1:0] status_vled
);

  reg_access_t           reg_acc;
  logic [ocl_data_w-1:0] rd_word;
  logic [ocl_data_w-1:0] hv_rd_data;
  logic                  hv_rd_hit;
  logic [ocl_data_w-1:0] tc_rd_data;
  logic                  tc_rd_hit;

  // --------------------------------------------------
  // Host bus
  // --------------------------------------------------
  axil_slave u_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (ocl_req),
    .rsp             (ocl_rsp),
    .reg_acc         (reg_acc),
    .rd_word         (rd_word)
  );

  // --------------------------------------------------
  // Register blocks
  // --------------------------------------------------
  hello_vled_regs u_hello_vled_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_acc         (reg_acc),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled),
    .rd_data         (hv_rd_data),
    .rd_hit          (hv_rd_hit)
  );

  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_acc         (reg_acc),
    .rd_data         (tc_rd_data),
    .rd_hit          (tc_rd_hit)
  );

  // Read merge, unmapped addresses give the marker word
  assign rd_word = hv_rd_hit ? hv_rd_data :
                   tc_rd_hit ? tc_rd_data :
                               unimpl_reg_value;

endmodule

/* src/tick_counter.sv */
// Tick counter: control registers, prescaler, main counter and watermark compare
module tick_counter
  import ocl_regs_pkg::*;
  import tick_counter_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  reg_access_t           reg_acc,
  output logic [ocl_data_w-1:0] rd_data,
  output logic                  rd_hit
);

  cnt_ctrl_t         ctrl_q;
  logic [tick_w-1:0] tick_value_q;
  logic [cnt_w-1:0]  load_value_q;
  logic [cnt_w-1:0]  watermark_q;
  logic [tick_w-1:0] tick_cnt_q;
  logic [cnt_w-1:0]  count_q;
  logic              tick_hit;
  cnt_status_t       status;

  // --------------------------------------------------
  // Host control registers
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q       <= '0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end else begin
      // load and clear drop again after one cycle
      ctrl_q.load  <= 1'b0;
      ctrl_q.clear <= 1'b0;
      if (reg_acc.wr_en) begin
        case (reg_acc.wr_addr)
          cnt_ctrl_addr:  ctrl_q       <= cnt_ctrl_t'(reg_acc.wr_data[$bits(cnt_ctrl_t)-1:0]);
          cnt_tick_addr:  tick_value_q <= reg_acc.wr_data[tick_w-1:0];
          cnt_load_addr:  load_value_q <= reg_acc.wr_data[cnt_w-1:0];
          cnt_wmark_addr: watermark_q  <= reg_acc.wr_data[cnt_w-1:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Prescaler and main counter
  // --------------------------------------------------
  assign tick_hit = tick_cnt_q >= tick_value_q;

  // Priority is clear, then load, then hold when disabled
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || ctrl_q.clear) begin
      tick_cnt_q <= '0;
      count_q    <= '0;
    end else begin
      if (ctrl_q.enable) begin
        tick_cnt_q <= tick_hit ? '0 : tick_cnt_q + 1'b1;
      end
      if (ctrl_q.load) begin
        count_q <= load_value_q;
      end else if (ctrl_q.enable && tick_hit) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Flag follows the current count
  assign status.count        = count_q;
  assign status.ge_watermark = count_q >= watermark_q;

  // Read decode, control reads back enable only
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (reg_acc.rd_addr)
      cnt_ctrl_addr:   rd_data[0]              = ctrl_q.enable;
      cnt_tick_addr:   rd_data[tick_w-1:0]     = tick_value_q;
      cnt_load_addr:   rd_data[cnt_w-1:0]      = load_value_q;
      cnt_wmark_addr:  rd_data[cnt_w-1:0]      = watermark_q;
      cnt_status_addr: rd_data[$bits(status)-1:0] = status;
      default:         rd_hit                  = 1'b0;
    endcase
  end

  // Pulses never stored across two cycles, writes are at least two cycles apart
  ast_pulse_once: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ctrl_q.load || ctrl_q.clear |=> !ctrl_q.load && !ctrl_q.clear);

endmodule

/* src/hello_vled_regs.sv */
// Hello world register with byte-swapped readback, VLED shadow, DIP sync and LED masking
module hello_vled_regs
  import ocl_regs_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  reg_access_t           reg_acc,
  input  logic [vled_w-1:0]     status_vdip,
  output logic [vled_w-1:0]     status_vled,
  output logic [ocl_data_w-1:0] rd_data,
  output logic                  rd_hit
);

  logic [ocl_data_w-1:0] hello_q;
  logic [ocl_data_w-1:0] hello_swapped;
  logic [vled_w-1:0]     vled_q;
  logic [vled_w-1:0]     vdip_q1;
  logic [vled_w-1:0]     vdip_q2;

  // --------------------------------------------------
  // Hello world register
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
    end else if (reg_acc.wr_en && (reg_acc.wr_addr == hello_world_addr)) begin
      hello_q <= reg_acc.wr_data;
    end
  end

  // Byte order reversed on readback
  assign hello_swapped = {<<8{hello_q}};

  // --------------------------------------------------
  // VLED shadow and DIP masking
  // --------------------------------------------------
  // Shadow trails the hello word by one cycle
  // DIP switches are asynchronous, two flops
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q      <= '0;
      vdip_q1     <= '0;
      vdip_q2     <= '0;
      status_vled <= '0;
    end else begin
      vled_q      <= hello_q[vled_w-1:0];
      vdip_q1     <= status_vdip;
      vdip_q2     <= vdip_q1;
      status_vled <= vled_q & vdip_q2;
    end
  end

  // Read decode
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    if (reg_acc.rd_addr == hello_world_addr) begin
      rd_data = hello_swapped;
    end else if (reg_acc.rd_addr == vled_addr) begin
      rd_data = {{(ocl_data_w - vled_w){1'b0}}, vled_q};
    end else begin
      rd_hit = 1'b0;
    end
  end

endmodule

/* src/axil_slave.sv */
// Single-beat AXI-Lite slave: write and read handshakes, register access strobes
module axil_slave
  import ocl_regs_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  axil_req_t             req,
  output axil_rsp_t             rsp,
  output reg_access_t           reg_acc,
  input  logic [ocl_data_w-1:0] rd_word
);

  // Write channel state
  logic                  wr_active;
  logic [ocl_addr_w-1:0] wr_addr_q;
  logic                  aw_hs;
  logic                  wready;
  logic                  bvalid_q;

  // Read channel state
  logic                  arready;
  logic                  arvalid_q;
  logic [ocl_addr_w-1:0] araddr_q;
  logic                  rvalid_q;
  logic [ocl_data_w-1:0] rdata_q;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  assign aw_hs = req.awvalid && !wr_active;

  // Data accepted once per write, never while the response is pending
  assign wready = wr_active && req.wvalid && !bvalid_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (wr_active && bvalid_q && req.bready) begin
      wr_active <= 1'b0;
    end else if (aw_hs) begin
      wr_active <= 1'b1;
    end
  end

  // Address held for the whole write
  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr_q <= req.awaddr;
    end
  end

  // Response one cycle after the data beat
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid_q <= 1'b0;
    end else if (bvalid_q && req.bready) begin
      bvalid_q <= 1'b0;
    end else if (wready) begin
      bvalid_q <= 1'b1;
    end
  end

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  // One read in flight, blocked while rdata waits for rready
  assign arready = !arvalid_q && !rvalid_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      arvalid_q <= 1'b0;
    end else begin
      arvalid_q <= req.arvalid && arready;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (req.arvalid && arready) begin
      araddr_q <= req.araddr;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid_q <= 1'b0;
    end else if (rvalid_q && req.rready) begin
      rvalid_q <= 1'b0;
    end else if (arvalid_q) begin
      rvalid_q <= 1'b1;
    end
  end

  // Decoded word sampled one cycle after the address
  always_ff @(posedge clk_main_a0) begin
    if (arvalid_q) begin
      rdata_q <= rd_word;
    end
  end

  // Bus outputs, responses always OKAY
  always_comb begin
    rsp.awready = !wr_active;
    rsp.wready  = wready;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = 2'b00;
    rsp.arready = arready;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = 2'b00;
  end

  // Strobes toward the register blocks
  always_comb begin
    reg_acc.wr_en   = wready;
    reg_acc.wr_addr = wr_addr_q;
    reg_acc.wr_data = req.wdata;
    reg_acc.rd_addr = araddr_q;
  end

  // Responses wait for the host
  ast_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.bvalid && !req.bready |=> rsp.bvalid);

  ast_rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata));

  // Data beat only inside an open write, answered on the next cycle
  ast_wready_active: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.wready |-> wr_active ##1 rsp.bvalid);

endmodule

/* src/tick_counter_pkg.sv */
// Tick counter widths and control / status register layouts
package tick_counter_pkg;

  // Main counter width
  localparam int cnt_w = 16;

  // Prescaler width
  localparam int tick_w = 8;

  // --------------------------------------------------
  // Control register, enable in bit 0
  // --------------------------------------------------
  typedef struct packed {
    logic clear;   // bit 2, one-cycle pulse
    logic load;    // bit 1, one-cycle pulse
    logic enable;  // bit 0, held
  } cnt_ctrl_t;

  // --------------------------------------------------
  // Status register
  // --------------------------------------------------
  // Count in the low bits, watermark flag just above
  typedef struct packed {
    logic             ge_watermark;
    logic [cnt_w-1:0] count;
  } cnt_status_t;

endpackage

/* src/ocl_regs_pkg.sv */
// Host register bus: widths, register map and AXI-Lite / register access structs
package ocl_regs_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ocl_addr_w = 32;
  localparam int ocl_data_w = 32;

  // LED and DIP switch width
  localparam int vled_w = 16;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam logic [ocl_addr_w-1:0] hello_world_addr = 32'h0000_0500;
  localparam logic [ocl_addr_w-1:0] vled_addr        = 32'h0000_0504;
  localparam logic [ocl_addr_w-1:0] cnt_ctrl_addr    = 32'h0000_0510;
  localparam logic [ocl_addr_w-1:0] cnt_tick_addr    = 32'h0000_0514;
  localparam logic [ocl_addr_w-1:0] cnt_load_addr    = 32'h0000_0518;
  localparam logic [ocl_addr_w-1:0] cnt_wmark_addr   = 32'h0000_051C;
  localparam logic [ocl_addr_w-1:0] cnt_status_addr  = 32'h0000_0520;

  // Read value for any address outside the map
  localparam logic [ocl_data_w-1:0] unimpl_reg_value = 32'hDEAD_DEAD;

  // Host-driven half of the AXI-Lite bus
  typedef struct packed {
    logic                  awvalid;
    logic [ocl_addr_w-1:0] awaddr;
    logic                  wvalid;
    logic [ocl_data_w-1:0] wdata;
    logic                  bready;
    logic                  arvalid;
    logic [ocl_addr_w-1:0] araddr;
    logic                  rready;
  } axil_req_t;

  // Slave-driven half
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic                  rvalid;
    logic [ocl_data_w-1:0] rdata;
    logic [1:0]            rresp;
  } axil_rsp_t;

  // Register side access, wr_en is a single-cycle pulse
  typedef struct packed {
    logic                  wr_en;
    logic [ocl_addr_w-1:0] wr_addr;
    logic [ocl_data_w-1:0] wr_data;
    logic [ocl_addr_w-1:0] rd_addr;
  } reg_access_t;

endpackage
